//--- tcam_pkg.sv
`default_nettype none

package tcam_pkg;

  // Key and table geometry
  localparam int KEY_W      = 144;
  localparam int SLICE_W    = 2;
  localparam int NUM_SLICES = KEY_W / SLICE_W;
  localparam int ROWS       = 1 << SLICE_W;

  // Rule storage
  localparam int ENTRIES    = 256;
  localparam int IDX_W      = $clog2(ENTRIES);

  // Priority encode is split into equal groups, group count equals group width
  localparam int GRP_W      = 16;
  localparam int NUM_GRPS   = ENTRIES / GRP_W;
  localparam int SUB_IDX_W  = $clog2(GRP_W);

  typedef logic [KEY_W-1:0]     key_t;
  typedef logic [SLICE_W-1:0]   slice_key_t;
  typedef logic [ENTRIES-1:0]   match_vec_t;
  typedef logic [IDX_W-1:0]     entry_idx_t;

  typedef logic [GRP_W-1:0]     sub_vec_t;     // One group of match bits
  typedef logic [SUB_IDX_W-1:0] sub_idx_t;     // Position inside a group

  // Rule write, 297 bits
  typedef struct packed {
    entry_idx_t entry;
    key_t       value;
    key_t       mask;                          // 1 marks a care bit
    logic       valid;                         // 0 clears the entry
  } tcam_write_t;

  // Search result, 9 bits
  typedef struct packed {
    logic       hit;
    entry_idx_t index;
  } tcam_result_t;

endpackage

`default_nettype wire

//--- slice_table.sv
`timescale 1ns/1ns
`default_nettype none

module slice_table (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       wr_valid,
  input  wire tcam_pkg::tcam_write_t wr,
  input  wire tcam_pkg::slice_key_t value_slice,
  input  wire tcam_pkg::slice_key_t mask_slice,
  input  wire tcam_pkg::slice_key_t key_slice,
  output tcam_pkg::match_vec_t      row
);

  import tcam_pkg::*;

  match_vec_t      tbl [ROWS];                 // One match vector per slice value
  logic [ROWS-1:0] col_bits;                   // New column for the written entry

  // A row matches the rule when it agrees with the value on every care bit
  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      col_bits[r] = wr.valid &&
                    (((slice_key_t'(r) ^ value_slice) & mask_slice) == '0);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < ROWS; r++) begin
        tbl[r] <= '0;                          // No entry valid after reset
      end
    end else if (wr_valid) begin
      for (int r = 0; r < ROWS; r++) begin
        tbl[r][wr.entry] <= col_bits[r];
      end
    end
  end

  // Search side reads the table as it stood before this edge's write
  assign row = tbl[key_slice];

endmodule

`default_nettype wire

//--- match_reduce.sv
`timescale 1ns/1ns
`default_nettype none

module match_reduce (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       search_valid,
  input  wire tcam_pkg::match_vec_t rows [tcam_pkg::NUM_SLICES],
  output logic                      match_valid,
  output tcam_pkg::match_vec_t      match
);

  import tcam_pkg::*;

  match_vec_t and_all;                         // Entries that hit on every slice

  always_comb begin
    and_all = '1;
    for (int s = 0; s < NUM_SLICES; s++) begin
      and_all &= rows[s];
    end
  end

  // Stage 1 valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      match_valid <= 1'b0;
    end else begin
      match_valid <= search_valid;
    end
  end

  // Stage 1 payload, loaded only for a real search
  always_ff @(posedge clk) begin
    if (search_valid) begin
      match <= and_all;
    end
  end

endmodule

`default_nettype wire

//--- priority_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module priority_encoder (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       match_valid,
  input  wire tcam_pkg::match_vec_t match,
  output logic                      result_valid,
  output tcam_pkg::tcam_result_t    result
);

  import tcam_pkg::*;

  // Lowest set bit of one group, 0 when the group is empty
  function automatic sub_idx_t first_set(sub_vec_t v);
    sub_idx_t idx;
    idx = '0;
    for (int i = GRP_W - 1; i >= 0; i--) begin
      if (v[i]) begin
        idx = sub_idx_t'(i);
      end
    end
    return idx;
  endfunction

  sub_vec_t     grp_any;                       // Any hit per group of GRP_W entries
  sub_idx_t     grp_sel;                       // First group with a hit
  sub_vec_t     grp_bits;
  sub_idx_t     bit_sel;
  tcam_result_t result_d;

  always_comb begin
    for (int g = 0; g < NUM_GRPS; g++) begin
      grp_any[g] = |match[g*GRP_W +: GRP_W];
    end
  end

  // Second level picks the lowest bit inside the winning group
  always_comb begin
    grp_sel        = first_set(grp_any);
    grp_bits       = match[grp_sel*GRP_W +: GRP_W];
    bit_sel        = first_set(grp_bits);
    result_d.hit   = |grp_any;
    result_d.index = {grp_sel, bit_sel};       // Zero on a miss
  end

  // Stage 2
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid <= match_valid;
      if (match_valid) begin
        result <= result_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- tcam_top.sv
`timescale 1ns/1ns
`default_nettype none

module tcam_top (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        search_valid,
  input  wire tcam_pkg::key_t        search_key,
  input  wire                        wr_valid,
  input  wire tcam_pkg::tcam_write_t wr,
  output tcam_pkg::tcam_result_t     result,
  output logic                       result_valid
);

  import tcam_pkg::*;

  wire match_vec_t slice_rows [NUM_SLICES];    // Selected row of each slice table
  wire match_vec_t match_vec;
  wire             match_valid;

  // One table per 2-bit key slice, slice s covers key bits 2s+1..2s
  for (genvar s = 0; s < NUM_SLICES; s++) begin : g_slice
    slice_table u_slice_table (
      .clk         (clk),
      .rst_n       (rst_n),
      .wr_valid    (wr_valid),
      .wr          (wr),
      .value_slice (wr.value[s*SLICE_W +: SLICE_W]),
      .mask_slice  (wr.mask[s*SLICE_W +: SLICE_W]),
      .key_slice   (search_key[s*SLICE_W +: SLICE_W]),
      .row         (slice_rows[s])
    );
  end

  match_reduce u_match_reduce (
    .clk          (clk),
    .rst_n        (rst_n),
    .search_valid (search_valid),
    .rows         (slice_rows),
    .match_valid  (match_valid),
    .match        (match_vec)
  );

  priority_encoder u_priority_encoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .match_valid  (match_valid),
    .match        (match_vec),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

//--- tcam_properties.sv
`timescale 1ns/1ns
`default_nettype none

module tcam_properties (
  input wire                         clk,
  input wire                         rst_n,
  input wire                         search_valid,
  input wire                         result_valid,
  input wire tcam_pkg::tcam_result_t result
);

  import tcam_pkg::*;

  // Two register stages between search strobe and result pulse
  a_latency : assert property (@(posedge clk) disable iff (!rst_n)
    result_valid == $past(search_valid, 2))
    else $error("result_valid is not search_valid delayed by two cycles");

  a_known : assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> !$isunknown(result))
    else $error("result has unknown bits while result_valid is high");

  a_miss_index : assert property (@(posedge clk) disable iff (!rst_n)
    !result.hit |-> result.index == '0)
    else $error("result index is not zero on a miss");

  a_reset_quiet : assert property (@(posedge clk)
    !rst_n |-> !result_valid)
    else $error("result_valid is high during reset");

endmodule

bind tcam_top tcam_properties u_tcam_properties (
  .clk          (clk),
  .rst_n        (rst_n),
  .search_valid (search_valid),
  .result_valid (result_valid),
  .result       (result)
);

`default_nettype wire

//--- tcam_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tcam_tb;

  import tcam_pkg::*;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         search_valid;
  key_t         search_key;
  logic         wr_valid;
  tcam_write_t  wr;
  logic         result_valid;
  tcam_result_t result;

  integer       seed = 32'h2033;
  key_t         m_value [ENTRIES];             // Reference rule storage
  key_t         m_mask  [ENTRIES];
  logic         m_valid [ENTRIES];
  tcam_result_t exp_q [$];                     // Expected results in issue order
  int           issue_q [$];                   // Cycle each search was issued
  int           cycle_cnt = 0;
  string        cur_test = "reset";
  int           checks = 0;
  int           errors = 0;
  int           timeouts = 0;
  int           tests_run = 0;
  int           test_checks;
  int           test_errors;
  key_t         prio_value;
  key_t         prio_mask;
  key_t         prio_key;

  tcam_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .search_valid (search_valid),
    .search_key   (search_key),
    .wr_valid     (wr_valid),
    .wr           (wr),
    .result       (result),
    .result_valid (result_valid)
  );

  always #20 clk = ~clk;

  function automatic key_t rand_key();
    key_t k;
    k = '0;
    for (int i = 0; i < 5; i++) begin
      k = {k[KEY_W-33:0], $random(seed)};
    end
    return k;
  endfunction

  // Key that agrees with the rule on care bits, random elsewhere
  function automatic key_t key_near(input key_t value, input key_t mask);
    return value ^ (rand_key() & ~mask);
  endfunction

  function automatic tcam_write_t make_write(input entry_idx_t entry, input key_t value,
                                             input key_t mask, input logic valid);
    tcam_write_t w;
    w.entry = entry;
    w.value = value;
    w.mask  = mask;
    w.valid = valid;
    return w;
  endfunction

  function automatic tcam_result_t model_search(input key_t key);
    tcam_result_t r;
    logic         found;
    r     = '0;
    found = 1'b0;
    for (int e = 0; e < ENTRIES; e++) begin
      if (!found && m_valid[e] && ((key ^ m_value[e]) & m_mask[e]) == '0) begin
        found   = 1'b1;
        r.hit   = 1'b1;
        r.index = entry_idx_t'(e);
      end
    end
    return r;
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    test_checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("error %s %s: expected %0h actual %0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("%0d tests, %0d checks, %0d errors, %0d timeouts",
             tests_run, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  // Outputs are sampled on the falling edge
  task automatic monitor_results();
    tcam_result_t exp_r;
    int           issue_t;
    forever begin
      @(negedge clk);
      if (rst_n && result_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          test_errors++;
          $display("%s: a result arrived with no search pending", cur_test);
        end else begin
          exp_r   = exp_q.pop_front();
          issue_t = issue_q.pop_front();
          check("hit", 32'(exp_r.hit), 32'(result.hit));
          check("index", 32'(exp_r.index), 32'(result.index));
          check("latency", issue_t + 2, cycle_cnt);
        end
      end
      cycle_cnt++;
    end
  endtask

  // Search reads the rules as they were before a write in the same cycle
  task automatic drive_cycle(input logic do_search, input key_t key,
                             input logic do_wr, input tcam_write_t w);
    if (do_search) begin
      exp_q.push_back(model_search(key));
      issue_q.push_back(cycle_cnt);
    end
    if (do_wr) begin
      m_value[w.entry] = w.value;
      m_mask[w.entry]  = w.mask;
      m_valid[w.entry] = w.valid;
    end
    search_valid <= do_search;
    search_key   <= key;
    wr_valid     <= do_wr;
    wr           <= w;
    @(posedge clk);
  endtask

  task automatic search(input key_t key);
    drive_cycle(1'b1, key, 1'b0, '0);
  endtask

  task automatic write_rule(input entry_idx_t e, input key_t v, input key_t m,
                            input logic valid);
    drive_cycle(1'b0, '0, 1'b1, make_write(e, v, m, valid));
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 10) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d search results did not arrive within 10 cycles",
               cur_test, exp_q.size());
      timeouts++;
      exp_q.delete();
      issue_q.delete();
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    drive_cycle(1'b0, '0, 1'b0, '0);
    drain();
    tests_run++;
    $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
  endtask

  task automatic search_empty_table();
    start_test("after_reset");
    for (int i = 0; i < 8; i++) begin
      search(rand_key());
    end
    end_test();
  endtask

  task automatic exact_rule_lookup();
    entry_idx_t ents [8];
    int         b;
    start_test("exact_rules");
    for (int i = 0; i < 8; i++) begin
      ents[i] = entry_idx_t'($random(seed));
      write_rule(ents[i], rand_key(), '1, 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      b = {$random(seed)} % KEY_W;
      search(m_value[ents[i]]);
      search(m_value[ents[i]] ^ (key_t'(1) << b));         // One cared bit off
    end
    end_test();
  endtask

  task automatic masked_rule_lookup();
    entry_idx_t ents [8];
    start_test("masked_rules");
    for (int i = 0; i < 8; i++) begin
      ents[i] = entry_idx_t'($random(seed));
      write_rule(ents[i], rand_key(), rand_key(), 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      search(key_near(m_value[ents[i]], m_mask[ents[i]]));
      search(key_near(m_value[ents[i]], m_mask[ents[i]]));
    end
    end_test();
  endtask

  task automatic priority_and_write_order();
    start_test("priority");
    prio_value = rand_key();
    prio_mask  = rand_key();
    prio_key   = key_near(prio_value, prio_mask);
    write_rule(8'd200, prio_value, prio_mask, 1'b1);
    write_rule(8'd100, prio_value, prio_mask, 1'b1);
    write_rule(8'd50, prio_value, prio_mask, 1'b1);
    search(prio_key);                                       // Lowest of three
    drive_cycle(1'b1, prio_key, 1'b1, make_write(8'd10, prio_value, prio_mask, 1'b1));
    search(prio_key);                                       // Now sees entry 10
    end_test();
  endtask

  task automatic invalidate_rules();
    start_test("invalidate");
    write_rule(8'd10, '0, '0, 1'b0);
    search(prio_key);
    write_rule(8'd50, '0, '0, 1'b0);
    search(prio_key);
    write_rule(8'd100, '0, '0, 1'b0);
    write_rule(8'd200, '0, '0, 1'b0);
    search(prio_key);
    end_test();
  endtask

  task automatic random_mix();
    logic        do_wr;
    logic        do_s;
    entry_idx_t  se;
    tcam_write_t w;
    start_test("random_mix");
    for (int i = 0; i < 300; i++) begin
      do_wr = ({$random(seed)} % 4) == 0;
      do_s  = ({$random(seed)} % 4) != 0;
      w     = make_write(entry_idx_t'({$random(seed)} % 32), rand_key(), rand_key(),
                         ({$random(seed)} % 8) != 0);
      se    = entry_idx_t'({$random(seed)} % 32);           // Small range keeps hits likely
      drive_cycle(do_s, key_near(m_value[se], m_mask[se]), do_wr, w);
    end
    end_test();
  endtask

  initial begin
    rst_n        <= 1'b0;
    search_valid <= 1'b0;
    search_key   <= '0;
    wr_valid     <= 1'b0;
    wr           <= '0;
    for (int e = 0; e < ENTRIES; e++) begin
      m_value[e] = '0;
      m_mask[e]  = '0;
      m_valid[e] = 1'b0;
    end
    fork
      monitor_results();
    join_none
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    search_empty_table();
    exact_rule_lookup();
    masked_rule_lookup();
    priority_and_write_order();
    invalidate_rules();
    random_mix();
    finish_run();
  end

endmodule

`default_nettype wire

//--- build.f
tcam_pkg.sv
slice_table.sv
match_reduce.sv
priority_encoder.sv
tcam_top.sv
tcam_properties.sv
tcam_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run the testbench, then search the log for failure
rm -f sim.log
verilator --binary --timing --assert --top-module tcam_tb -f build.f -o tcam_sim \
  && ./obj_dir/tcam_sim > sim.log 2>&1 \
  || echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
